//--- fetch_unit.f
source/fetch_pkg.sv
source/imss_if.sv
source/fetch_pc_gen.sv
source/inst_mem.sv
source/fetch_predecode.sv
source/fetch_unit.sv
verif/fetch_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --top-module fetch_unit_tb \
    --Mdir "$BUILD_DIR" -o fetch_unit_sim \
    -f fetch_unit.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BUILD_DIR/fetch_unit_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- source/fetch_pc_gen.sv
/*
 * Fetch stage 1: PC register, post-reset init cycle, stall and redirect
 * handling, and the fetch address presented to instruction memory
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_pc_gen #(
    parameter fetch_pkg::pc_t RESET_PC = 32'h0000_0000
) (
    input  wire                  clk,
    input  wire                  rst_n,

    // PC load from the redirect arbiter
    input  wire                  pc_load_en,
    input  wire fetch_pkg::pc_t  pc_load_val,

    // Hazard control
    input  wire                  f1_stall,
    input  wire                  f1_flush,

    imss_if.fetch1               imss,

    // To stage 2
    output logic                 f1_valid,
    output fetch_pkg::f1_to_f2_s f1_to_f2
);

    logic           f1_init;
    fetch_pkg::pc_t pc_q;
    fetch_pkg::pc_t next_pc;
    fetch_pkg::pc_t fetch_addr;

    // First cycle out of reset has no response to pair with
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            f1_init <= 1'b1;
        end else begin
            f1_init <= 1'b0;
        end
    end

    // Loaded target wins over the sequential PC
    always_comb begin
        if (pc_load_en) begin
            next_pc = pc_load_val;
        end else begin
            next_pc = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (!f1_stall && !f1_init) begin
            pc_q <= next_pc;
        end
    end

    // Memory has no address enable, so the address must track what pc_q
    // will hold after the edge; while held, re-read the current PC
    always_comb begin
        if (f1_stall || f1_init) begin
            fetch_addr = pc_q;
        end else begin
            fetch_addr = next_pc;
        end
    end

    // Request is always issued and a flush just overwrites it next cycle
    assign imss.req_valid = 1'b1;
    assign imss.req_addr  = fetch_addr;

    // Response now on the bus belongs to pc_q
    assign f1_valid    = !f1_init && !f1_flush && !f1_stall;
    assign f1_to_f2.pc = pc_q;

    // Init flag is a single pulse after reset
    a_init_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        f1_init |=> !f1_init)
        else $error("f1_init longer than one cycle");

    // Held address keeps the memory response matched to pc_q
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        f1_stall |-> $stable(fetch_addr))
        else $error("fetch address moved under stall");

    // Arbiter in the top must never ask for both
    a_no_stall_flush: assert property (@(posedge clk) disable iff (!rst_n)
        !(f1_stall && f1_flush))
        else $error("stage 1 stalled and flushed together");

endmodule

`default_nettype wire

//--- source/fetch_pkg.sv
/*
 * Shared fetch types: PC and instruction words, the J/B-type views of one word,
 * the stage 1 to stage 2 transfer struct and the RISC-V opcode constants
 */
`default_nettype none

package fetch_pkg;

    // Byte address of an instruction
    typedef logic [31:0] pc_t;

    // Raw instruction word as fetched
    typedef logic [31:0] inst_t;

    // Major opcodes that predecode looks for
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

    // J-type layout, immediate pieces in ISA bit order
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_s;

    // B-type layout, bit 31 is the sign of the offset
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_s;

    // Same 32 bits, decoded both ways by predecode
    typedef union packed {
        j_type_s j;
        b_type_s b;
    } inst_u;

    // Handed from stage 1 to stage 2 alongside f1_valid
    typedef struct packed {
        pc_t pc;
    } f1_to_f2_s;

endpackage

`default_nettype wire

//--- source/fetch_predecode.sv
/*
 * Fetch stage 2: pairs each response with its PC, registers the output pair,
 * and predicts JAL and backward-branch targets (static backward taken)
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_predecode (
    input  wire                       clk,
    input  wire                       rst_n,

    // From stage 1
    input  wire                       f1_valid,
    input  wire fetch_pkg::f1_to_f2_s f1_to_f2,

    // Hazard control
    input  wire                       f2_stall,
    input  wire                       f2_flush,

    imss_if.fetch2                    imss,

    // Predicted redirect back to stage 1
    output logic                      pred_redirect,
    output fetch_pkg::pc_t            pred_target,

    // To the back end
    output logic                      inst_valid,
    output fetch_pkg::pc_t            inst_pc,
    output fetch_pkg::inst_t          inst
);

    fetch_pkg::inst_u word;
    logic             accept;
    logic             is_jal;
    logic             is_bwd_branch;
    logic [31:0]      j_imm;
    logic [31:0]      b_imm;
    logic             pred_taken_q;

    // Same word, viewed as J-type and as B-type
    assign word = imss.rsp_inst;

    assign is_jal        = (word.j.opcode == fetch_pkg::OPCODE_JAL);
    // Sign bit set means the branch goes backwards
    assign is_bwd_branch = (word.b.opcode == fetch_pkg::OPCODE_BRANCH) && word.b.imm12;

    assign j_imm = {{11{word.j.imm20}}, word.j.imm20, word.j.imm19_12,
                    word.j.imm11, word.j.imm10_1, 1'b0};
    assign b_imm = {{19{word.b.imm12}}, word.b.imm12, word.b.imm11,
                    word.b.imm10_5, word.b.imm4_1, 1'b0};

    assign accept = f1_valid && imss.rsp_valid && !f2_stall;

    // Control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inst_valid   <= 1'b0;
            pred_taken_q <= 1'b0;
        end else if (f2_flush) begin
            inst_valid   <= 1'b0;
            pred_taken_q <= 1'b0;
        end else if (!f2_stall) begin
            inst_valid   <= accept;
            pred_taken_q <= accept && (is_jal || is_bwd_branch);
        end
    end

    // Payload, target computed from the incoming PC
    always_ff @(posedge clk) begin
        if (accept) begin
            inst_pc <= f1_to_f2.pc;
            inst    <= imss.rsp_inst;
            if (is_jal) begin
                pred_target <= f1_to_f2.pc + j_imm;
            end else begin
                pred_target <= f1_to_f2.pc + b_imm;
            end
        end
    end

    // Fires while the taken instruction is on the output, which squashes
    // the sequential fetch sitting in stage 1; held back during a stall
    assign pred_redirect = inst_valid && pred_taken_q && !f2_stall;

    // The redirect must loop back through the arbiter and kill stage 1
    a_redirect_squash: assert property (@(posedge clk) disable iff (!rst_n)
        pred_redirect |-> !f1_valid)
        else $error("wrong-path fetch survived a predicted redirect");

    // Stage 1 only hands over words the memory actually returned
    a_rsp_present: assert property (@(posedge clk) disable iff (!rst_n)
        f1_valid |-> imss.rsp_valid)
        else $error("stage 1 valid without a memory response");

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(inst_valid))
        else $error("inst_valid unknown");

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
/*
 * Fetch front end top: PC generation, instruction memory and predecode,
 * plus redirect priority and stall/flush distribution
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
    parameter int             IMEM_WORDS = 256,
    parameter fetch_pkg::pc_t RESET_PC   = 32'h0000_0000
) (
    input  wire                            clk,
    input  wire                            rst_n,

    // Back-end control
    input  wire                            stall,
    input  wire                            redirect,
    input  wire fetch_pkg::pc_t            redirect_pc,

    // Instruction memory load port
    input  wire                            imem_wr_en,
    input  wire [$clog2(IMEM_WORDS)-1:0]   imem_wr_addr,
    input  wire fetch_pkg::inst_t          imem_wr_data,

    // Instruction stream to the back end
    output logic                           ready,
    output logic                           inst_valid,
    output fetch_pkg::pc_t                 inst_pc,
    output fetch_pkg::inst_t               inst
);

    logic                 pc_load_en;
    fetch_pkg::pc_t       pc_load_val;
    logic                 f1_stall;
    logic                 f1_flush;
    logic                 f2_stall;
    logic                 f2_flush;
    logic                 f1_valid;
    fetch_pkg::f1_to_f2_s f1_to_f2;
    logic                 pred_redirect;
    fetch_pkg::pc_t       pred_target;

    imss_if imss ();

    // Front end never refuses work
    assign ready = 1'b1;

    // Back-end redirect beats the predicted one
    assign pc_load_en  = redirect || pred_redirect;
    assign pc_load_val = redirect ? redirect_pc : pred_target;

    // Stage 1 is squashed by either redirect, stage 2 only by the back end
    assign f1_flush = pc_load_en;
    assign f2_flush = redirect;

    // A redirect overrides a stall in the same cycle
    assign f1_stall = stall && !pc_load_en;
    assign f2_stall = stall && !redirect;

    fetch_pc_gen #(
        .RESET_PC    (RESET_PC)
    ) u_pc_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_load_en  (pc_load_en),
        .pc_load_val (pc_load_val),
        .f1_stall    (f1_stall),
        .f1_flush    (f1_flush),
        .imss        (imss.fetch1),
        .f1_valid    (f1_valid),
        .f1_to_f2    (f1_to_f2)
    );

    inst_mem #(
        .IMEM_WORDS (IMEM_WORDS)
    ) u_inst_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (imem_wr_en),
        .wr_addr    (imem_wr_addr),
        .wr_data    (imem_wr_data),
        .imss       (imss.mem)
    );

    fetch_predecode u_predecode (
        .clk           (clk),
        .rst_n         (rst_n),
        .f1_valid      (f1_valid),
        .f1_to_f2      (f1_to_f2),
        .f2_stall      (f2_stall),
        .f2_flush      (f2_flush),
        .imss          (imss.fetch2),
        .pred_redirect (pred_redirect),
        .pred_target   (pred_target),
        .inst_valid    (inst_valid),
        .inst_pc       (inst_pc),
        .inst          (inst)
    );

endmodule

`default_nettype wire

//--- source/imss_if.sv
/*
 * Request/response link between the fetch stages and instruction memory
 */
`timescale 1ns/100ps
`default_nettype none

interface imss_if;

    // Request side, issued every cycle by stage 1
    logic             req_valid;
    fetch_pkg::pc_t   req_addr;

    // Response side, one cycle after the request
    logic             rsp_valid;
    fetch_pkg::inst_t rsp_inst;

    // Stage 1 only drives the request
    modport fetch1 (
        output req_valid,
        output req_addr
    );

    // Stage 2 only consumes the response
    modport fetch2 (
        input rsp_valid,
        input rsp_inst
    );

    // Memory side
    modport mem (
        input  req_valid,
        input  req_addr,
        output rsp_valid,
        output rsp_inst
    );

endinterface

`default_nettype wire

//--- source/inst_mem.sv
/*
 * Instruction memory: word array with one-cycle registered read on the
 * fetch request and a plain write port for loading
 */
`timescale 1ns/100ps
`default_nettype none

module inst_mem #(
    parameter int IMEM_WORDS = 256
) (
    input  wire                            clk,
    input  wire                            rst_n,

    // Load port, word indexed
    input  wire                            wr_en,
    input  wire [$clog2(IMEM_WORDS)-1:0]   wr_addr,
    input  wire fetch_pkg::inst_t          wr_data,

    imss_if.mem                            imss
);

    localparam int IDX_W = $clog2(IMEM_WORDS);

    fetch_pkg::inst_t mem [IMEM_WORDS];
    logic [IDX_W-1:0] rd_idx;

    // Byte address to word index, upper bits wrap
    assign rd_idx = imss.req_addr[IDX_W+1:2];

    // Loading is allowed while the core is held in reset
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data register
    always_ff @(posedge clk) begin
        imss.rsp_inst <= mem[rd_idx];
    end

    // Response valid follows the request by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            imss.rsp_valid <= 1'b0;
        end else begin
            imss.rsp_valid <= imss.req_valid;
        end
    end

    // No compressed instructions, so every fetch is word aligned
    a_req_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imss.req_valid |-> (imss.req_addr[1:0] == 2'b00))
        else $error("misaligned fetch address");

endmodule

`default_nettype wire

//--- verif/fetch_unit_tb.sv
/*
 * Testbench for the fetch front end: memory load, random stall and redirect
 * stimulus, a next-PC reference model and concurrent output checks
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit_tb;

    localparam int             IMEM_WORDS   = 64;
    localparam int             IDX_W        = $clog2(IMEM_WORDS);
    localparam fetch_pkg::pc_t RESET_PC     = 32'h0000_0000;
    localparam int             CLK_PERIOD   = 8;
    localparam int             RESET_CYCLES = 8;
    localparam int             NUM_XFERS    = 500;
    // Load time plus a generous eight cycles per accepted instruction
    localparam int             MAX_CYCLES   = RESET_CYCLES + IMEM_WORDS + NUM_XFERS * 8 + 100;

    logic             clk;
    logic             rst_n;
    logic             stall;
    logic             redirect;
    fetch_pkg::pc_t   redirect_pc;
    logic             imem_wr_en;
    logic [IDX_W-1:0] imem_wr_addr;
    fetch_pkg::inst_t imem_wr_data;
    logic             ready;
    logic             inst_valid;
    fetch_pkg::pc_t   inst_pc;
    fetch_pkg::inst_t inst;

    // Reference model state
    fetch_pkg::inst_t shadow [IMEM_WORDS];
    fetch_pkg::pc_t   exp_pc;
    logic [15:0]      lfsr = 16'd68;
    int               xfers = 0;

    // One-cycle history of control and outputs
    logic             rst_q;
    logic             stall_q;
    logic             redirect_q;
    logic             prev_valid;
    fetch_pkg::pc_t   prev_pc;
    fetch_pkg::inst_t prev_inst;

    int               data_errs = 0;
    int               order_errs = 0;
    int               hold_errs = 0;
    int               ctrl_errs = 0;

    fetch_unit #(
        .IMEM_WORDS   (IMEM_WORDS),
        .RESET_PC     (RESET_PC)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .imem_wr_en   (imem_wr_en),
        .imem_wr_addr (imem_wr_addr),
        .imem_wr_data (imem_wr_data),
        .ready        (ready),
        .inst_valid   (inst_valid),
        .inst_pc      (inst_pc),
        .inst         (inst)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Program word for one memory slot
    function automatic fetch_pkg::inst_t make_word(input int idx);
        logic [31:0] r;
        logic [2:0]  kind;
        r    = rand_bits(32);
        kind = 3'(rand_bits(3));
        // First words stay straight-line so the sequential start is visible
        if (idx < 8 || kind >= 3'd4) begin
            return {r[31:7], 7'b0010011};
        end else if (kind <= 3'd1) begin
            // imm[1] cleared so jump targets stay word aligned
            return {r[31:22], 1'b0, r[20:7], fetch_pkg::OPCODE_JAL};
        end else if (kind == 3'd2) begin
            // Sign bit set, backward branch
            return {1'b1, r[30:9], 1'b0, r[7], fetch_pkg::OPCODE_BRANCH};
        end
        return {1'b0, r[30:9], 1'b0, r[7], fetch_pkg::OPCODE_BRANCH};
    endfunction

    // Memory wraps on the low address bits
    function automatic fetch_pkg::inst_t shadow_word(input fetch_pkg::pc_t pc);
        return shadow[pc[IDX_W+1:2]];
    endfunction

    // Static prediction: JAL and backward branches taken, all else falls through
    function automatic fetch_pkg::pc_t next_pc_of(input fetch_pkg::pc_t pc,
                                                  input fetch_pkg::inst_t w);
        logic [31:0] j_off;
        logic [31:0] b_off;
        j_off = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        b_off = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        if (w[6:0] == fetch_pkg::OPCODE_JAL) begin
            return pc + j_off;
        end else if (w[6:0] == fetch_pkg::OPCODE_BRANCH && w[31]) begin
            return pc + b_off;
        end
        return pc + 32'd4;
    endfunction

    // Expected PC of the next accepted instruction
    always @(posedge clk) begin
        rst_q      <= rst_n;
        stall_q    <= stall;
        redirect_q <= redirect;
        prev_valid <= inst_valid;
        prev_pc    <= inst_pc;
        prev_inst  <= inst;
        if (!rst_n) begin
            exp_pc <= RESET_PC;
        end else if (redirect) begin
            exp_pc <= redirect_pc;
        end else if (inst_valid && !stall) begin
            exp_pc <= next_pc_of(exp_pc, shadow_word(exp_pc));
            xfers  <= xfers + 1;
        end
    end

    // Output word always matches the loaded program
    a_inst_data: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |-> inst == shadow_word(inst_pc))
        else begin
            data_errs++;
            $display("[FAIL] t=%0t inst expected %h got %h", $time,
                     shadow_word($sampled(inst_pc)), $sampled(inst));
        end

    // Accepted PCs follow sequential, predicted and redirected flow
    a_pc_order: assert property (@(posedge clk) disable iff (!rst_n)
        (inst_valid && !stall && !redirect) |-> inst_pc == exp_pc)
        else begin
            order_errs++;
            $display("[FAIL] t=%0t inst_pc expected %h got %h", $time,
                     $sampled(exp_pc), $sampled(inst_pc));
        end

    // Nothing moves across a stalled cycle
    a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (rst_q && stall_q && !redirect_q) |-> inst_valid == prev_valid)
        else begin
            hold_errs++;
            $display("[FAIL] t=%0t inst_valid expected %b got %b", $time,
                     $sampled(prev_valid), $sampled(inst_valid));
        end

    a_hold_data: assert property (@(posedge clk) disable iff (!rst_n)
        (stall_q && !redirect_q && prev_valid) |->
            (inst_pc == prev_pc && inst == prev_inst))
        else begin
            hold_errs++;
            $display("[FAIL] t=%0t inst_pc expected %h got %h, inst expected %h got %h",
                     $time, $sampled(prev_pc), $sampled(inst_pc),
                     $sampled(prev_inst), $sampled(inst));
        end

    // Idle output right after reset release
    a_reset_idle: assert property (@(posedge clk)
        (rst_n && !rst_q) |-> !inst_valid)
        else begin
            ctrl_errs++;
            $display("[FAIL] t=%0t inst_valid expected 0 got %b", $time, $sampled(inst_valid));
        end

    a_ready: assert property (@(posedge clk) ready)
        else begin
            ctrl_errs++;
            $display("[FAIL] t=%0t ready expected 1 got %b", $time, $sampled(ready));
        end

    initial begin
        rst_n        = 1'b0;
        stall        = 1'b1;
        redirect     = 1'b0;
        redirect_pc  = '0;
        imem_wr_en   = 1'b0;
        imem_wr_addr = '0;
        imem_wr_data = '0;

        // Load starts under reset, stall keeps fetch parked until it ends
        for (int i = 0; i < IMEM_WORDS; i++) begin
            @(negedge clk);
            imem_wr_en   = 1'b1;
            imem_wr_addr = IDX_W'(i);
            imem_wr_data = make_word(i);
            shadow[i]    = imem_wr_data;
            if (i == RESET_CYCLES - 1) begin
                rst_n = 1'b1;
            end
        end
        @(negedge clk);
        imem_wr_en = 1'b0;
        // Held fetch re-reads RESET_PC and now sees its final word
        @(negedge clk);

        // Straight-line start without stall
        stall = 1'b0;
        repeat (12) @(negedge clk);

        // Random back-end stall and redirect
        while (xfers < NUM_XFERS) begin
            @(negedge clk);
            stall       = (rand_bits(2) == 32'd0);
            redirect    = (rand_bits(4) == 32'd0);
            redirect_pc = rand_bits(IDX_W) << 2;
        end
        @(negedge clk);
        stall    = 1'b0;
        redirect = 1'b0;
        repeat (4) @(negedge clk);

        $display("errors: data=%0d order=%0d hold=%0d control=%0d accepted=%0d",
                 data_errs, order_errs, hold_errs, ctrl_errs, xfers);
        if (data_errs + order_errs + hold_errs + ctrl_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles with only %0d instructions accepted",
                 MAX_CYCLES, xfers);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
